//--- files.f
tap_game_pkg.sv
judge_bus_if.sv
spawn_rate_reg.sv
arrow_spawner.sv
arrow_track.sv
hit_judge.sv
score_keeper.sv
score_display.sv
tap_game.sv
tb_clock_gen.sv
tap_game_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the tap game testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tap_game_tb -f files.f -o tap_game_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tap_game_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "sim failed" "$log"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

//--- tap_game_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tap_game_tb import tap_game_pkg::*; ();

    localparam int act_skip    = 0;
    localparam int act_correct = 1;
    localparam int act_wrong   = 2;
    localparam int act_early   = 3;

    localparam int zone_mid  = (int'(zone_lo) + int'(zone_hi)) / 2;
    localparam int early_mid = (int'(early_lo) + int'(early_hi)) / 2;
    // Slowest game, arrow flight, blink sequence and some slack
    localparam int game_cycles = int'(spawn_slow) + (int'(spawn_slow) + 1) * (arrows_per_game - 1)
        + (int'(spawn_y) + 2) * move_period + blink_steps * blink_period + 200;
    localparam int watchdog_cycles = 4 * game_cycles + 3000;
    localparam int end_limit = blink_steps * blink_period + 8 * move_period + 50;

    logic             my_6p25mhz_clock;
    logic             rst;
    logic             start_game;
    logic             btn_up;
    logic             btn_down;
    logic             btn_left;
    logic             btn_right;
    logic [mic_w-1:0] mic_in;
    logic [seg_w-1:0] seg_an3;
    logic [seg_w-1:0] seg_an2;
    logic [seg_w-1:0] seg_an1;
    logic [seg_w-1:0] seg_an0;
    logic             end_game;
    logic             lose;
    int               pos_count = 0;
    int               game_start = 0;
    int               mode [arrows_per_game];

    tb_clock_gen clock_gen_i (.my_6p25mhz_clock(my_6p25mhz_clock), .rst(rst));

    tap_game tap_game_i (
        .my_6p25mhz_clock(my_6p25mhz_clock), .rst(rst), .start_game(start_game),
        .btn_up(btn_up), .btn_down(btn_down), .btn_left(btn_left), .btn_right(btn_right),
        .mic_in(mic_in), .seg_an3(seg_an3), .seg_an2(seg_an2), .seg_an1(seg_an1),
        .seg_an0(seg_an0), .end_game(end_game), .lose(lose)
    );

    always @(posedge my_6p25mhz_clock) begin
        pos_count <= pos_count + 1;
    end

    task automatic end_in_failure();
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic show_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual);
        end_in_failure();
    endtask

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        end_in_failure();
    endtask

    task automatic check_segments(input int shown_score);
        logic [seg_w-1:0] tens_code;
        logic [seg_w-1:0] units_code;
        tens_code  = seg_digit[shown_score / 10];
        units_code = seg_digit[shown_score % 10];
        assert (seg_an3 == tens_code)
            else show_mismatch("seg_an3", 32'(tens_code), 32'(seg_an3));
        assert (seg_an2 == units_code)
            else show_mismatch("seg_an2", 32'(units_code), 32'(seg_an2));
        assert (seg_an1 == seg_digit[2])
            else show_mismatch("seg_an1", 32'(seg_digit[2]), 32'(seg_an1));
        assert (seg_an0 == seg_digit[0])
            else show_mismatch("seg_an0", 32'(seg_digit[0]), 32'(seg_an0));
    endtask

    task automatic check_idle();
        assert (end_game == 1'b0) else show_mismatch("end_game", 0, 32'(end_game));
        assert (lose == 1'b0) else show_mismatch("lose", 0, 32'(lose));
        check_segments(0);
    endtask

    // Game cycle n is the state after the n-th rising edge of the game
    task automatic wait_game_cycle(input int n);
        while (pos_count - game_start < n) begin
            @(negedge my_6p25mhz_clock);
        end
    endtask

    task automatic clear_game();
        start_game = 1'b0;
        repeat (2) @(negedge my_6p25mhz_clock);
        check_idle();
    endtask

    task automatic drive_button(input int lane_idx, input logic on);
        btn_left  = on && lane_idx == 0;
        btn_up    = on && lane_idx == 1;
        btn_right = on && lane_idx == 2;
        btn_down  = on && lane_idx == 3;
    endtask

    function automatic int spawn_cycle(input logic [mic_w-1:0] mic, input int j);
        int pattern;
        int interval;
        pattern = int'(mic) % pattern_mod;
        if (pattern <= 3) begin
            interval = int'(spawn_slow);
        end else if (pattern <= 7) begin
            interval = int'(spawn_mid);
        end else begin
            interval = int'(spawn_fast);
        end
        return interval + (interval + 1) * j; // Count runs 0 to interval
    endfunction

    // Last game cycle before the arrow drops to this height
    function automatic int height_cycle(input int spawned, input int height);
        int first_drop;
        first_drop = spawned - (spawned % move_period) + move_period - 1;
        if (first_drop == spawned) begin
            first_drop += move_period;
        end
        return first_drop + (int'(spawn_y) - height - 1) * move_period;
    endfunction

    task automatic choose_presses(input int base, input int disturbed);
        int idx;
        int marked;
        foreach (mode[j]) begin
            mode[j] = base;
        end
        marked = 0;
        while (marked < disturbed) begin
            idx = int'($urandom_range(arrows_per_game - 1, 0));
            if (mode[idx] == act_correct) begin
                mode[idx] = ($urandom_range(1, 0) == 0) ? act_wrong : act_early;
                marked++;
            end
        end
    endtask

    task automatic play_arrows(input logic [mic_w-1:0] mic, input int count, output int hits);
        int lane_idx;
        int press_at;
        lane_idx   = int'(mic) % 4;
        hits       = 0;
        mic_in     = mic;
        start_game = 1'b1;
        game_start = pos_count;
        for (int j = 0; j < count; j++) begin
            press_at = height_cycle(spawn_cycle(mic, j),
                                    (mode[j] == act_early) ? early_mid : zone_mid) + 2;
            wait_game_cycle(press_at + 1);
            if (mode[j] == act_correct || mode[j] == act_early) begin
                drive_button(lane_idx, 1'b1);
            end else if (mode[j] == act_wrong) begin
                drive_button((lane_idx + 1) % 4, 1'b1);
            end
            wait_game_cycle(press_at + 5); // Held over exactly one judge tick
            drive_button(lane_idx, 1'b0);
            wait_game_cycle(press_at + 8);
            if (mode[j] == act_correct) begin
                hits++;
            end
            check_segments(hits);
        end
    endtask

    task automatic finish_game(input int final_score);
        logic expect_lose;
        bit   was_blank;
        int   blank_runs;
        int   blank_cycles;
        int   waited;
        expect_lose  = final_score <= lose_max_score;
        was_blank    = 1'b0;
        blank_runs   = 0;
        blank_cycles = 0;
        waited       = 0;
        while (!end_game) begin
            if (waited == end_limit) begin
                stop_with_error("end_game did not rise after the last arrow");
            end
            assert (lose == 1'b0) else show_mismatch("lose", 0, 32'(lose));
            if (seg_an3 == seg_blank) begin
                assert (seg_an2 == seg_blank && seg_an1 == seg_blank && seg_an0 == seg_blank)
                    else stop_with_error("segments only partly blanked during the blink");
                if (!was_blank) begin
                    blank_runs++; // Start of a blank phase
                end
                blank_cycles++;
                was_blank = 1'b1;
            end else begin
                check_segments(final_score);
                was_blank = 1'b0;
            end
            waited++;
            @(negedge my_6p25mhz_clock);
        end
        // Blink starts dark-free, so every other step is blank
        assert (blank_runs == blink_steps / 2)
            else show_mismatch("seg_an3 blank phases", 32'(blink_steps / 2), 32'(blank_runs));
        assert (blank_cycles == (blink_steps / 2) * blink_period)
            else show_mismatch("seg_an3 blank cycles", 32'((blink_steps / 2) * blink_period),
                               32'(blank_cycles));
        assert (lose == expect_lose) else show_mismatch("lose", 32'(expect_lose), 32'(lose));
        repeat (2 * blink_period) begin
            @(negedge my_6p25mhz_clock);
            assert (end_game == 1'b1) else show_mismatch("end_game", 1, 32'(end_game));
            assert (lose == expect_lose) else show_mismatch("lose", 32'(expect_lose), 32'(lose));
            check_segments(final_score); // Frozen after the end
        end
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge my_6p25mhz_clock);
        stop_with_error("timeout, the games did not finish in the expected time");
    end

    initial begin
        int hits;
        start_game = 1'b0;
        btn_up     = 1'b0;
        btn_down   = 1'b0;
        btn_left   = 1'b0;
        btn_right  = 1'b0;
        mic_in     = '0;
        void'($urandom(32'ha581_4180));
        @(negedge rst);
        @(negedge my_6p25mhz_clock);
        check_idle();

        choose_presses(act_skip, 0); // Every arrow expires
        play_arrows(12'h005, arrows_per_game, hits);
        finish_game(hits);
        clear_game();

        choose_presses(act_correct, 0);
        play_arrows(12'h00a, arrows_per_game, hits);
        finish_game(hits);
        clear_game();

        choose_presses(act_correct, 5); // Score 15, a win
        play_arrows(12'h000, arrows_per_game, hits);
        finish_game(hits);
        clear_game();

        choose_presses(act_correct, 6); // Score 14, a loss
        play_arrows(12'h013, arrows_per_game, hits);
        finish_game(hits);
        clear_game();

        choose_presses(act_correct, 0);
        play_arrows(12'h00a, 2, hits);
        clear_game(); // Abort in mid-game

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int half_period  = 20,
    parameter int reset_cycles = 3
) (
    output logic my_6p25mhz_clock,
    output logic rst
);

    initial begin
        my_6p25mhz_clock = 1'b0;
        forever #(half_period) my_6p25mhz_clock = ~my_6p25mhz_clock; // 40 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(negedge my_6p25mhz_clock); // Released on a falling edge
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- tap_game.sv
`timescale 1ns/1ps
`default_nettype none

module tap_game import tap_game_pkg::*; (
    input  logic             my_6p25mhz_clock,
    input  logic             rst,
    input  logic             start_game,
    input  logic             btn_up,
    input  logic             btn_down,
    input  logic             btn_left,
    input  logic             btn_right,
    input  logic [mic_w-1:0] mic_in,
    output logic [seg_w-1:0] seg_an3,
    output logic [seg_w-1:0] seg_an2,
    output logic [seg_w-1:0] seg_an1,
    output logic [seg_w-1:0] seg_an0,
    output logic             end_game,
    output logic             lose
);

    logic [spawn_w-1:0] spawn_interval;
    logic               spawn;
    logic [lane_w-1:0]  spawn_lane;
    logic [count_w-1:0] score;
    logic               blink_on;

    judge_bus_if bus_i ();

    spawn_rate_reg spawn_rate_reg_i (
        .my_6p25mhz_clock(my_6p25mhz_clock), .rst(rst), .start_game(start_game),
        .mic_in(mic_in), .spawn_interval(spawn_interval)
    );

    arrow_spawner arrow_spawner_i (
        .my_6p25mhz_clock(my_6p25mhz_clock), .rst(rst), .start_game(start_game),
        .mic_in(mic_in), .spawn_interval(spawn_interval),
        .spawn(spawn), .spawn_lane(spawn_lane)
    );

    arrow_track arrow_track_i (
        .my_6p25mhz_clock(my_6p25mhz_clock), .rst(rst), .start_game(start_game),
        .spawn(spawn), .spawn_lane(spawn_lane), .bus(bus_i.track)
    );

    hit_judge hit_judge_i (
        .my_6p25mhz_clock(my_6p25mhz_clock), .rst(rst), .start_game(start_game),
        .btn_left(btn_left), .btn_up(btn_up), .btn_right(btn_right),
        .btn_down(btn_down), .bus(bus_i.judge)
    );

    score_keeper score_keeper_i (
        .my_6p25mhz_clock(my_6p25mhz_clock), .rst(rst), .start_game(start_game),
        .bus(bus_i.score), .score(score), .blink_on(blink_on),
        .end_game(end_game), .lose(lose)
    );

    score_display score_display_i (
        .my_6p25mhz_clock(my_6p25mhz_clock), .rst(rst), .start_game(start_game),
        .score(score), .blink_on(blink_on),
        .seg_an3(seg_an3), .seg_an2(seg_an2), .seg_an1(seg_an1), .seg_an0(seg_an0)
    );

endmodule

`default_nettype wire

//--- score_display.sv
`timescale 1ns/1ps
`default_nettype none

module score_display import tap_game_pkg::*; (
    input  logic               my_6p25mhz_clock,
    input  logic               rst,
    input  logic               start_game,
    input  logic [count_w-1:0] score,
    input  logic               blink_on,
    output logic [seg_w-1:0]   seg_an3,
    output logic [seg_w-1:0]   seg_an2,
    output logic [seg_w-1:0]   seg_an1,
    output logic [seg_w-1:0]   seg_an0
);

    logic [3:0] tens;
    logic [3:0] units;

    assign tens  = 4'(score / 5'd10);
    assign units = 4'(score % 5'd10);

    always_ff @(posedge my_6p25mhz_clock) begin
        if (rst || !start_game) begin
            seg_an3 <= seg_digit[0];
            seg_an2 <= seg_digit[0];
            seg_an1 <= seg_digit[2];
            seg_an0 <= seg_digit[0];
        end else if (blink_on) begin
            seg_an3 <= seg_blank;
            seg_an2 <= seg_blank;
            seg_an1 <= seg_blank;
            seg_an0 <= seg_blank;
        end else begin
            seg_an3 <= seg_digit[tens];
            seg_an2 <= seg_digit[units];
            seg_an1 <= seg_digit[2]; // Fixed "20", the arrows per game
            seg_an0 <= seg_digit[0];
        end
    end

endmodule

`default_nettype wire

//--- score_keeper.sv
`timescale 1ns/1ps
`default_nettype none

module score_keeper import tap_game_pkg::*; (
    input  logic               my_6p25mhz_clock,
    input  logic               rst,
    input  logic               start_game,
    judge_bus_if.score         bus,
    output logic [count_w-1:0] score,
    output logic               blink_on,
    output logic               end_game,
    output logic               lose
);

    logic [count_w-1:0]      fail_cnt;
    logic [count_w:0]        total;
    logic                    done;
    logic                    die;
    logic [tick_w-1:0]       blink_cnt;
    logic [blink_step_w-1:0] blink_step;

    assign total    = {1'b0, score} + {1'b0, fail_cnt};
    assign done     = total == (count_w + 1)'(arrows_per_game);
    assign blink_on = blink_step[0]; // Odd steps blank the display

    always_ff @(posedge my_6p25mhz_clock) begin
        if (rst || !start_game) begin
            score      <= '0;
            fail_cnt   <= '0;
            die        <= 1'b0;
            blink_cnt  <= '0;
            blink_step <= '0;
            end_game   <= 1'b0;
            lose       <= 1'b0;
        end else begin
            if (bus.hit) begin
                score <= score + 1'b1;
            end
            if (bus.miss) begin
                fail_cnt <= fail_cnt + 1'b1;
            end
            if (done && !end_game) begin
                die <= score <= count_w'(lose_max_score);
                if (blink_cnt == tick_w'(blink_period - 1)) begin
                    blink_cnt <= '0;
                    if (blink_step == blink_step_w'(blink_steps - 1)) begin
                        blink_step <= '0;
                        end_game   <= 1'b1; // Held until a clear
                        lose       <= die;
                    end else begin
                        blink_step <= blink_step + 1'b1;
                    end
                end else begin
                    blink_cnt <= blink_cnt + 1'b1;
                end
            end
        end
    end

    total_in_range: assert property (
        @(posedge my_6p25mhz_clock) disable iff (rst)
        total <= (count_w + 1)'(arrows_per_game)
    ) else $error("score plus fail above arrows per game");

endmodule

`default_nettype wire

//--- hit_judge.sv
`timescale 1ns/1ps
`default_nettype none

module hit_judge import tap_game_pkg::*; (
    input  logic       my_6p25mhz_clock,
    input  logic       rst,
    input  logic       start_game,
    input  logic       btn_left,
    input  logic       btn_up,
    input  logic       btn_right,
    input  logic       btn_down,
    judge_bus_if.judge bus
);

    logic [tick_w-1:0] judge_cnt;
    logic              judge_tick;
    logic              any_btn;
    logic              in_zone;
    logic              in_early;
    logic [lane_w-1:0] pressed_lane;

    assign judge_tick = judge_cnt == tick_w'(judge_period - 1);
    assign any_btn    = btn_left || btn_up || btn_right || btn_down;
    assign in_zone    = bus.head_y >= zone_lo && bus.head_y <= zone_hi;
    assign in_early   = bus.head_y >= early_lo && bus.head_y <= early_hi;

    always_ff @(posedge my_6p25mhz_clock) begin
        if (rst || !start_game) begin
            judge_cnt <= '0;
        end else begin
            judge_cnt <= judge_tick ? '0 : judge_cnt + 1'b1;
        end
    end

    always_comb begin
        pressed_lane = btn_left  ? lane_left  :
                       btn_up    ? lane_up    :
                       btn_right ? lane_right : lane_down; // Left first
        bus.hit  = 1'b0;
        bus.miss = 1'b0;
        if (bus.head_lane != lane_none) begin
            if (bus.head_y == expire_y) begin
                bus.miss = 1'b1; // Passed the zone, no tick needed
            end else if (judge_tick && any_btn) begin
                if (in_zone) begin
                    bus.hit  = pressed_lane == bus.head_lane;
                    bus.miss = pressed_lane != bus.head_lane;
                end else if (in_early) begin
                    bus.miss = 1'b1;
                end
            end
        end
    end

    // One pulse per retired arrow, the next head is far above the zone
    judge_pulse_single: assert property (
        @(posedge my_6p25mhz_clock) disable iff (rst || !start_game)
        (bus.hit || bus.miss) |=> !(bus.hit || bus.miss)
    ) else $error("judge pulse held for more than one cycle");

endmodule

`default_nettype wire

//--- arrow_track.sv
`timescale 1ns/1ps
`default_nettype none

module arrow_track import tap_game_pkg::*; (
    input  logic              my_6p25mhz_clock,
    input  logic              rst,
    input  logic              start_game,
    input  logic              spawn,
    input  logic [lane_w-1:0] spawn_lane,
    judge_bus_if.track        bus
);

    logic [lane_w-1:0]     lane_q [num_slots];
    logic [pos_w-1:0]      y_q [num_slots];
    logic [slot_idx_w-1:0] spawn_idx;
    logic [slot_idx_w-1:0] head_idx;
    logic [tick_w-1:0]     move_cnt;
    logic                  move_tick;
    logic                  clear;
    logic                  retire;

    function automatic logic [slot_idx_w-1:0] next_idx(input logic [slot_idx_w-1:0] idx);
        return (idx == slot_idx_w'(num_slots - 1)) ? '0 : idx + 1'b1; // Ring wrap
    endfunction

    assign clear     = rst || !start_game;
    assign move_tick = move_cnt == tick_w'(move_period - 1);
    assign retire    = bus.hit || bus.miss;

    assign bus.head_lane = lane_q[head_idx];
    assign bus.head_y    = y_q[head_idx];

    always_ff @(posedge my_6p25mhz_clock) begin
        if (clear) begin
            move_cnt  <= '0;
            spawn_idx <= '0;
            head_idx  <= '0;
            for (int i = 0; i < num_slots; i++) begin
                lane_q[i] <= lane_none;
            end
        end else begin
            move_cnt <= move_tick ? '0 : move_cnt + 1'b1;
            if (retire) begin
                lane_q[head_idx] <= lane_none;
                head_idx         <= next_idx(head_idx);
            end
            if (spawn) begin
                lane_q[spawn_idx] <= spawn_lane; // New arrow wins over a retire
                spawn_idx         <= next_idx(spawn_idx);
            end
        end
    end

    always_ff @(posedge my_6p25mhz_clock) begin
        if (clear) begin
            for (int i = 0; i < num_slots; i++) begin
                y_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_slots; i++) begin
                if (move_tick && lane_q[i] != lane_none) begin
                    y_q[i] <= y_q[i] - 1'b1; // Climb one step
                end
            end
            if (spawn) begin
                y_q[spawn_idx] <= spawn_y;
            end
        end
    end

    retire_needs_arrow: assert property (
        @(posedge my_6p25mhz_clock) disable iff (clear)
        retire |-> bus.head_lane != lane_none
    ) else $error("hit or miss with empty head slot");

endmodule

`default_nettype wire

//--- arrow_spawner.sv
`timescale 1ns/1ps
`default_nettype none

module arrow_spawner import tap_game_pkg::*; (
    input  logic               my_6p25mhz_clock,
    input  logic               rst,
    input  logic               start_game,
    input  logic [mic_w-1:0]   mic_in,
    input  logic [spawn_w-1:0] spawn_interval,
    output logic               spawn,
    output logic [lane_w-1:0]  spawn_lane
);

    logic [spawn_w-1:0] spawn_cnt;
    logic [count_w-1:0] arrow_cnt;
    logic               all_spawned;

    assign all_spawned = arrow_cnt == count_w'(arrows_per_game);
    // Interval can shrink under a running count, so compare with >=
    assign spawn = !all_spawned && (spawn_cnt >= spawn_interval);
    // 0 left, 1 up, 2 right, 3 down
    assign spawn_lane = lane_w'(mic_in % 4) + lane_left;

    always_ff @(posedge my_6p25mhz_clock) begin
        if (rst || !start_game) begin
            spawn_cnt <= '0;
            arrow_cnt <= '0;
        end else if (spawn) begin
            spawn_cnt <= '0;
            arrow_cnt <= arrow_cnt + 1'b1;
        end else if (!all_spawned) begin
            spawn_cnt <= spawn_cnt + 1'b1;
        end
    end

    spawn_lane_valid: assert property (
        @(posedge my_6p25mhz_clock) disable iff (rst)
        spawn |-> spawn_lane != lane_none
    ) else $error("spawn with empty lane code");

endmodule

`default_nettype wire

//--- spawn_rate_reg.sv
`timescale 1ns/1ps
`default_nettype none

module spawn_rate_reg import tap_game_pkg::*; (
    input  logic               my_6p25mhz_clock,
    input  logic               rst,
    input  logic               start_game,
    input  logic [mic_w-1:0]   mic_in,
    output logic [spawn_w-1:0] spawn_interval
);

    logic [tick_w-1:0]    pattern_cnt;
    logic [pattern_w-1:0] pattern;
    logic                 pattern_tick;

    assign pattern_tick = pattern_cnt == tick_w'(pattern_period - 1);

    always_ff @(posedge my_6p25mhz_clock) begin
        if (rst || !start_game) begin
            pattern_cnt <= '0;
            pattern     <= '0;
        end else begin
            pattern_cnt <= pattern_tick ? '0 : pattern_cnt + 1'b1;
            if (pattern_tick) begin
                pattern <= pattern_w'(mic_in % pattern_mod); // Resample from mic
            end
        end
    end

    always_comb begin
        if (pattern <= pattern_w'(3)) begin
            spawn_interval = spawn_slow;
        end else if (pattern <= pattern_w'(7)) begin
            spawn_interval = spawn_mid;
        end else begin
            spawn_interval = spawn_fast;
        end
    end

endmodule

`default_nettype wire

//--- judge_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface judge_bus_if
    import tap_game_pkg::*;
();

    logic [lane_w-1:0] head_lane; // Oldest arrow in flight
    logic [pos_w-1:0]  head_y;
    logic              hit;
    logic              miss;

    modport track (output head_lane, output head_y, input hit, input miss);
    modport judge (input head_lane, input head_y, output hit, output miss);
    modport score (input hit, input miss);

endinterface

`default_nettype wire

//--- tap_game_pkg.sv
`default_nettype none

package tap_game_pkg;

    localparam int num_slots  = 10;
    localparam int slot_idx_w = 4;

    localparam int lane_w = 3;
    localparam logic [lane_w-1:0] lane_none  = 3'd0; // Empty slot
    localparam logic [lane_w-1:0] lane_left  = 3'd1;
    localparam logic [lane_w-1:0] lane_up    = 3'd2;
    localparam logic [lane_w-1:0] lane_right = 3'd3;
    localparam logic [lane_w-1:0] lane_down  = 3'd4;

    localparam int pos_w = 7;
    localparam logic [pos_w-1:0] spawn_y  = 7'd55;
    localparam logic [pos_w-1:0] zone_lo  = 7'd3;
    localparam logic [pos_w-1:0] zone_hi  = 7'd7;
    localparam logic [pos_w-1:0] early_lo = 7'd8;
    localparam logic [pos_w-1:0] early_hi = 7'd12;
    localparam logic [pos_w-1:0] expire_y = 7'd2;

    localparam int arrows_per_game = 20;
    localparam int lose_max_score  = 14;
    localparam int count_w         = 5;

    // Timer periods in clock cycles, scaled down from the board
    localparam int tick_w         = 8;
    localparam int judge_period   = 4;
    localparam int move_period    = 8;
    localparam int blink_period   = 80;
    localparam int blink_steps    = 7;
    localparam int blink_step_w   = 3;
    localparam int pattern_period = 160;

    localparam int spawn_w = 9;
    localparam logic [spawn_w-1:0] spawn_slow = 9'd264; // Patterns 0 to 3
    localparam logic [spawn_w-1:0] spawn_mid  = 9'd216; // Patterns 4 to 7
    localparam logic [spawn_w-1:0] spawn_fast = 9'd160; // Patterns 8 to 11
    localparam int pattern_w   = 4;
    localparam int pattern_mod = 12;
    localparam int mic_w       = 12;

    localparam int seg_w = 8;
    localparam logic [seg_w-1:0] seg_blank = 8'b1111_1111;
    // Active low, index is the digit
    localparam logic [seg_w-1:0] seg_digit [0:9] = '{
        8'b0000_0011, 8'b1001_1111, 8'b0010_0101, 8'b0000_1101, 8'b1001_1001,
        8'b0100_1001, 8'b1100_0001, 8'b0001_1111, 8'b0000_0001, 8'b0001_1001
    };

endpackage

`default_nettype wire
